/* all.f */
+incdir+hw
hw/board_pkg.sv
hw/board_regs.sv
hw/four_way_filter.sv
hw/joy_mapper.sv
hw/pause_ctrl.sv
hw/board_inputs_top.sv
verif/tb_board_inputs.sv

/* hw/board_defs.svh */
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// player count and joystick word widths
`define BOARD_PLAYERS 4
`define BOARD_JOY_W 16
`define BOARD_GAME_JOY_W 10

// direction bits sit in the low nibble of the raw word
`define BOARD_DIR_W 4

// button positions in the raw word with two game buttons fitted
`define BOARD_START_BIT 6
`define BOARD_COIN_BIT 7
`define BOARD_PAUSE_BIT 8

// game side polarity where 1 inverts every input bit
`define BOARD_INPUTS_ACTIVE_LOW 1'b1

// register port widths
`define BOARD_AXI_AW 4
`define BOARD_AXI_DW 32

// register map
`define BOARD_REG_CFG 4'h0
`define BOARD_REG_STATUS 4'h4

// config register bit map
`define BOARD_CFG_ROTATE_BIT 0
`define BOARD_CFG_FLIP_BIT 1
`define BOARD_CFG_4WAY_BIT 2
`define BOARD_CFG_OSD_PAUSE_BIT 3
`define BOARD_CFG_DIP_TEST_BIT 4

`endif

/* hw/board_inputs_top.sv */
`default_nettype none

`include "board_defs.svh"

module board_inputs_top
    import board_pkg::*;
(
    input  logic                                       clk_sys,
    input  logic                                       rst,
    input  logic                                       downloading,
    input  axil_req_t                                  axil_req,
    output axil_rsp_t                                  axil_rsp,
    input  joy_raw_t [`BOARD_PLAYERS-1:0]              board_joy,
    output logic [`BOARD_PLAYERS-1:0][`BOARD_GAME_JOY_W-1:0] game_joy,
    output logic [`BOARD_PLAYERS-1:0]                  game_coin,
    output logic [`BOARD_PLAYERS-1:0]                  game_start,
    output logic                                       game_pause,
    output logic                                       dip_test
);

    board_cfg_t                cfg;
    logic [`BOARD_PLAYERS-1:0] joy_pause;

    board_regs u_regs (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .game_pause (game_pause),
        .cfg        (cfg)
    );

    joy_mapper u_mapper (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .board_joy  (board_joy),
        .cfg        (cfg),
        .game_joy   (game_joy),
        .game_coin  (game_coin),
        .game_start (game_start),
        .joy_pause  (joy_pause)
    );

    pause_ctrl u_pause (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .downloading (downloading),
        .joy_pause   (joy_pause),
        .osd_pause   (cfg.osd_pause),
        .game_pause  (game_pause)
    );

    // test DIP straight from the settings register
    assign dip_test = cfg.dip_test;

endmodule

`default_nettype wire

/* hw/board_pkg.sv */
`default_nettype none

`include "board_defs.svh"

package board_pkg;

    // one raw joystick word as delivered by the board
    typedef struct packed {
        // buttons, start, coin and pause
        logic [`BOARD_JOY_W-`BOARD_DIR_W-1:0] upper;
        // up, down, left, right from msb to lsb
        logic [`BOARD_DIR_W-1:0]              dirs;
    } joy_raw_t;

    // settings with rotate on bit 0
    typedef struct packed {
        logic dip_test;
        logic osd_pause;
        logic en_4way;
        logic flip;
        logic rotate;
    } board_cfg_t;

    // direction kept by the 4-way filter
    typedef enum logic [2:0] {
        dir_none,
        dir_right,
        dir_left,
        dir_down,
        dir_up
    } dir_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axil_resp_e;

    // manager to subordinate
    typedef struct packed {
        logic                       awvalid;
        logic [`BOARD_AXI_AW-1:0]   awaddr;
        logic                       wvalid;
        logic [`BOARD_AXI_DW-1:0]   wdata;
        logic [`BOARD_AXI_DW/8-1:0] wstrb;
        logic                       bready;
        logic                       arvalid;
        logic [`BOARD_AXI_AW-1:0]   araddr;
        logic                       rready;
    } axil_req_t;

    // subordinate to manager
    typedef struct packed {
        logic                     awready;
        logic                     wready;
        logic                     bvalid;
        axil_resp_e               bresp;
        logic                     arready;
        logic                     rvalid;
        logic [`BOARD_AXI_DW-1:0] rdata;
        axil_resp_e               rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

/* hw/board_regs.sv */
`default_nettype none

`include "board_defs.svh"

module board_regs
    import board_pkg::*;
(
    input  logic       clk_sys,
    input  logic       rst,
    input  axil_req_t  axil_req,
    output axil_rsp_t  axil_rsp,
    input  logic       game_pause,
    output board_cfg_t cfg
);

    localparam int cfg_w = $bits(board_cfg_t);

    // write channel
    logic       bvalid_q;
    axil_resp_e bresp_q;
    logic       wr_take;
    logic       wr_cfg;
    logic       wr_status;

    // read channel
    logic                     rvalid_q;
    axil_resp_e               rresp_q;
    logic [`BOARD_AXI_DW-1:0] rdata_q;
    logic [`BOARD_AXI_DW-1:0] rd_word;
    logic                     rd_take;
    logic                     rd_hit;

    board_cfg_t cfg_q;

    // address and data arrive together while nothing is pending
    assign wr_take   = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign wr_cfg    = (axil_req.awaddr == `BOARD_REG_CFG);
    assign wr_status = (axil_req.awaddr == `BOARD_REG_STATUS);

    assign rd_take = axil_req.arvalid && !rvalid_q;

    // read mux with zeros above the stored bits
    always_comb begin
        rd_word = '0;
        rd_hit  = 1'b1;
        case (axil_req.araddr)
            `BOARD_REG_CFG: begin
                rd_word[cfg_w-1:0] = cfg_q;
            end
            `BOARD_REG_STATUS: begin
                rd_word[0] = game_pause;
            end
            default: begin
                rd_hit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            cfg_q    <= '0;
        end else begin
            if (wr_take) begin
                bvalid_q <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end

            if (rd_take) begin
                rvalid_q <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end

            // settings live in byte 0 only
            if (wr_take && wr_cfg && axil_req.wstrb[0]) begin
                cfg_q <= axil_req.wdata[cfg_w-1:0];
            end
        end
    end

    // response payload held while the valid flags wait
    always_ff @(posedge clk_sys) begin
        if (wr_take) begin
            if (wr_cfg || wr_status) begin
                bresp_q <= resp_okay;
            end else begin
                bresp_q <= resp_slverr;
            end
        end

        if (rd_take) begin
            rdata_q <= rd_word;
            if (rd_hit) begin
                rresp_q <= resp_okay;
            end else begin
                rresp_q <= resp_slverr;
            end
        end
    end

    always_comb begin
        axil_rsp.awready = !bvalid_q;
        axil_rsp.wready  = !bvalid_q;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = !rvalid_q;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

    assign cfg = cfg_q;

endmodule

`default_nettype wire

/* hw/four_way_filter.sv */
`default_nettype none

module four_way_filter
    import board_pkg::*;
(
    input  logic       clk_sys,
    input  logic       rst,
    input  logic       enable,
    input  logic [3:0] dirs_in,
    output logic [3:0] dirs_out
);

    dir_e       last_q;
    dir_e       last_next;
    logic [3:0] last_mask;
    logic [3:0] filt;

    // bit order is up, down, left, right
    function automatic logic [3:0] dir_mask(input dir_e d);
        case (d)
            dir_up:    dir_mask = 4'b1000;
            dir_down:  dir_mask = 4'b0100;
            dir_left:  dir_mask = 4'b0010;
            dir_right: dir_mask = 4'b0001;
            default:   dir_mask = 4'b0000;
        endcase
    endfunction

    function automatic dir_e mask_dir(input logic [3:0] m);
        case (m)
            4'b1000: mask_dir = dir_up;
            4'b0100: mask_dir = dir_down;
            4'b0010: mask_dir = dir_left;
            4'b0001: mask_dir = dir_right;
            default: mask_dir = dir_none;
        endcase
    endfunction

    assign last_mask = dir_mask(last_q);

    always_comb begin
        last_next = last_q;
        filt      = dirs_in;
        if (!enable) begin
            last_next = dir_none;
        end else if (dirs_in == 4'b0000) begin
            last_next = dir_none;
        end else if ($onehot(dirs_in)) begin
            last_next = mask_dir(dirs_in);
        end else begin
            // diagonal keeps only the direction held before
            filt = dirs_in & last_mask;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_q   <= dir_none;
            dirs_out <= 4'b0000;
        end else begin
            last_q   <= last_next;
            dirs_out <= filt;
        end
    end

endmodule

`default_nettype wire

/* hw/joy_mapper.sv */
`default_nettype none

`include "board_defs.svh"

module joy_mapper
    import board_pkg::*;
(
    input  logic                                             clk_sys,
    input  logic                                             rst,
    input  joy_raw_t   [`BOARD_PLAYERS-1:0]                  board_joy,
    input  board_cfg_t                                       cfg,
    output logic       [`BOARD_PLAYERS-1:0][`BOARD_GAME_JOY_W-1:0] game_joy,
    output logic       [`BOARD_PLAYERS-1:0]                  game_coin,
    output logic       [`BOARD_PLAYERS-1:0]                  game_start,
    output logic       [`BOARD_PLAYERS-1:0]                  joy_pause
);

    localparam logic invert_inputs = `BOARD_INPUTS_ACTIVE_LOW;
    localparam int   upper_w       = `BOARD_JOY_W - `BOARD_DIR_W;
    localparam int   game_w        = `BOARD_GAME_JOY_W;

    // stage 1 synchroniser
    joy_raw_t [`BOARD_PLAYERS-1:0] sync_q;

    // stage 2 filtered directions with the upper bits kept in step
    logic [`BOARD_PLAYERS-1:0][upper_w-1:0]      upper_q;
    logic [`BOARD_PLAYERS-1:0][`BOARD_DIR_W-1:0] filt_dirs;
    joy_raw_t [`BOARD_PLAYERS-1:0]               stage_w;

    // vertical monitor rotation on the low nibble
    function automatic logic [game_w-1:0] apply_rotation(
        input logic [game_w-1:0] joy,
        input logic              rot,
        input logic              flip
    );
        logic [3:0] d;
        d = joy[3:0];
        if (rot && flip) begin
            d = {joy[1], joy[0], joy[2], joy[3]};
        end else if (rot) begin
            d = {joy[0], joy[1], joy[3], joy[2]};
        end
        apply_rotation = {joy[game_w-1:4], d};
    endfunction

    always_ff @(posedge clk_sys) begin
        sync_q <= board_joy;
        for (int p = 0; p < `BOARD_PLAYERS; p++) begin
            upper_q[p] <= sync_q[p].upper;
        end
    end

    for (genvar p = 0; p < `BOARD_PLAYERS; p++) begin : g_player
        four_way_filter u_filter (
            .clk_sys  (clk_sys),
            .rst      (rst),
            .enable   (cfg.en_4way),
            .dirs_in  (sync_q[p].dirs),
            .dirs_out (filt_dirs[p])
        );

        assign stage_w[p] = {upper_q[p], filt_dirs[p]};

        // pause stays active high for the pause logic
        assign joy_pause[p] = stage_w[p][`BOARD_PAUSE_BIT];
    end

    // stage 3 output register in game polarity
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joy   <= {(`BOARD_PLAYERS*game_w){invert_inputs}};
            game_coin  <= {`BOARD_PLAYERS{invert_inputs}};
            game_start <= {`BOARD_PLAYERS{invert_inputs}};
        end else begin
            for (int p = 0; p < `BOARD_PLAYERS; p++) begin
                game_joy[p] <= {game_w{invert_inputs}} ^
                    apply_rotation(stage_w[p][game_w-1:0], cfg.rotate, cfg.flip);
                game_coin[p]  <= invert_inputs ^ stage_w[p][`BOARD_COIN_BIT];
                game_start[p] <= invert_inputs ^ stage_w[p][`BOARD_START_BIT];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/pause_ctrl.sv */
`default_nettype none

`include "board_defs.svh"

module pause_ctrl
    import board_pkg::*;
(
    input  logic                      clk_sys,
    input  logic                      rst,
    input  logic                      downloading,
    input  logic [`BOARD_PLAYERS-1:0] joy_pause,
    input  logic                      osd_pause,
    output logic                      game_pause
);

    // only players 1 and 2 can pause
    logic [1:0] last_joy_q;
    logic       last_osd_q;
    logic       joy_edge;
    logic       osd_change;

    assign joy_edge   = |(joy_pause[1:0] & ~last_joy_q);
    assign osd_change = osd_pause ^ last_osd_q;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_joy_q <= 2'b00;
            last_osd_q <= 1'b0;
            game_pause <= 1'b0;
        end else begin
            last_joy_q <= joy_pause[1:0];
            last_osd_q <= osd_pause;
            if (downloading) begin
                game_pause <= 1'b0;
            end else if (osd_change) begin
                // menu wins over a joystick toggle
                game_pause <= osd_pause;
            end else if (joy_edge) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the board input testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_board_inputs -f all.f -Mdir obj_dir -o tb_board_inputs
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_board_inputs
status=$?
if [ $status -ne 0 ]; then
    echo "simulation run failed"
    exit $status
fi
exit 0

/* verif/tb_board_inputs.sv */
`default_nettype none

`include "board_defs.svh"

module tb_board_inputs
    import board_pkg::*;
();

    localparam int clk_period      = 40;
    localparam int handshake_limit = 20;
    // rough cycles for reset and each test in order
    localparam int test_cycles = 6 + 100 + 70 + 110 + 25 + 50;

    logic                                             clk_sys;
    logic                                             rst;
    logic                                             downloading;
    axil_req_t                                        axil_req;
    axil_rsp_t                                        axil_rsp;
    joy_raw_t [`BOARD_PLAYERS-1:0]                    board_joy;
    logic [`BOARD_PLAYERS-1:0][`BOARD_GAME_JOY_W-1:0] game_joy;
    logic [`BOARD_PLAYERS-1:0]                        game_coin;
    logic [`BOARD_PLAYERS-1:0]                        game_start;
    logic                                             game_pause;
    logic                                             dip_test;
    integer                                           seed;

    board_inputs_top DUT (.*);

    always #(clk_period / 2) clk_sys = ~clk_sys;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("error %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    task automatic axil_write(input logic [`BOARD_AXI_AW-1:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output axil_resp_e resp);
        int waited;
        waited = 0;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        axil_req.bready  = 1'b0;
        while (!(axil_rsp.awready && axil_rsp.wready)) begin
            @(negedge clk_sys);
            waited++;
            if (waited > handshake_limit) begin
                abort_run("the write address and data were never accepted");
            end
        end
        @(negedge clk_sys);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        // response held back so nothing new may be taken
        repeat (3) begin
            check("write bvalid held", 1, 32'(axil_rsp.bvalid));
            check("write blocked", 0, 32'(axil_rsp.awready));
            check("write data blocked", 0, 32'(axil_rsp.wready));
            @(negedge clk_sys);
        end
        resp = axil_rsp.bresp;
        axil_req.bready = 1'b1;
        @(negedge clk_sys);
        axil_req.bready = 1'b0;
        check("write bvalid cleared", 0, 32'(axil_rsp.bvalid));
    endtask

    task automatic axil_read(input logic [`BOARD_AXI_AW-1:0] addr,
                             output logic [31:0] data, output axil_resp_e resp);
        int waited;
        waited = 0;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        axil_req.rready  = 1'b0;
        while (!axil_rsp.arready) begin
            @(negedge clk_sys);
            waited++;
            if (waited > handshake_limit) begin
                abort_run("the read address was never accepted");
            end
        end
        @(negedge clk_sys);
        axil_req.arvalid = 1'b0;
        repeat (3) begin
            check("read rvalid held", 1, 32'(axil_rsp.rvalid));
            check("read blocked", 0, 32'(axil_rsp.arready));
            @(negedge clk_sys);
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        axil_req.rready = 1'b1;
        @(negedge clk_sys);
        axil_req.rready = 1'b0;
        check("read rvalid cleared", 0, 32'(axil_rsp.rvalid));
    endtask

    task automatic write_cfg(input string name, input logic [31:0] value);
        axil_resp_e resp;
        axil_write(`BOARD_REG_CFG, value, 4'hF, resp);
        check(name, 32'(resp_okay), 32'(resp));
    endtask

    task automatic expect_read(input string name, input logic [`BOARD_AXI_AW-1:0] addr,
                               input logic [31:0] want, input axil_resp_e want_resp);
        logic [31:0] data;
        axil_resp_e  resp;
        axil_read(addr, data, resp);
        check({name, " resp"}, 32'(want_resp), 32'(resp));
        if (want_resp == resp_okay) begin
            check(name, want, data);
        end
    endtask

    // direction order up, down, left, right from bit 3
    function automatic logic [3:0] turn_dirs(input logic [3:0] d, input logic rot,
                                             input logic flip);
        logic up, down, left, right;
        {up, down, left, right} = d;
        if (!rot) begin
            return d;
        end
        if (flip) begin
            return {left, right, down, up};
        end
        return {right, left, up, down};
    endfunction

    function automatic logic [`BOARD_GAME_JOY_W-1:0] game_word(input joy_raw_t raw,
                                                               input logic [3:0] dirs);
        return {`BOARD_GAME_JOY_W{`BOARD_INPUTS_ACTIVE_LOW}} ^
            {raw[`BOARD_GAME_JOY_W-1:4], dirs};
    endfunction

    // outputs must hold for two cycles and change on the third
    task automatic drive_and_compare(input string name,
                                     input joy_raw_t [`BOARD_PLAYERS-1:0] joys,
                                     input logic [`BOARD_PLAYERS-1:0][9:0] want);
        logic [`BOARD_PLAYERS-1:0][`BOARD_GAME_JOY_W-1:0] held;
        held = game_joy;
        board_joy = joys;
        repeat (2) @(negedge clk_sys);
        for (int p = 0; p < `BOARD_PLAYERS; p++) begin
            check({name, " latency"}, 32'(held[p]), 32'(game_joy[p]));
        end
        @(negedge clk_sys);
        for (int p = 0; p < `BOARD_PLAYERS; p++) begin
            check(name, 32'(want[p]), 32'(game_joy[p]));
            check({name, " coin"}, 32'(`BOARD_INPUTS_ACTIVE_LOW ^ joys[p][`BOARD_COIN_BIT]),
                  32'(game_coin[p]));
            check({name, " start"}, 32'(`BOARD_INPUTS_ACTIVE_LOW ^ joys[p][`BOARD_START_BIT]),
                  32'(game_start[p]));
        end
    endtask

    task automatic reset_and_registers();
        axil_resp_e resp;
        for (int p = 0; p < `BOARD_PLAYERS; p++) begin
            check("idle joy", 32'({`BOARD_GAME_JOY_W{`BOARD_INPUTS_ACTIVE_LOW}}),
                  32'(game_joy[p]));
        end
        check("idle coin", 32'({`BOARD_PLAYERS{`BOARD_INPUTS_ACTIVE_LOW}}), 32'(game_coin));
        check("idle start", 32'({`BOARD_PLAYERS{`BOARD_INPUTS_ACTIVE_LOW}}), 32'(game_start));
        check("idle pause", 0, 32'(game_pause));
        check("idle dip", 0, 32'(dip_test));
        check("idle bvalid", 0, 32'(axil_rsp.bvalid));
        check("idle rvalid", 0, 32'(axil_rsp.rvalid));
        expect_read("cfg after reset", `BOARD_REG_CFG, 32'h0, resp_okay);
        expect_read("status after reset", `BOARD_REG_STATUS, 32'h0, resp_okay);
        write_cfg("cfg write", 32'h15);
        expect_read("cfg readback", `BOARD_REG_CFG, 32'h15, resp_okay);
        check("dip follows cfg", 1, 32'(dip_test));
        // byte 0 disabled so the settings must stay
        axil_write(`BOARD_REG_CFG, 32'hFFFF_FFFF, 4'hE, resp);
        check("cfg upper strobes resp", 32'(resp_okay), 32'(resp));
        expect_read("cfg byte 0 kept", `BOARD_REG_CFG, 32'h15, resp_okay);
        axil_write(`BOARD_REG_STATUS, 32'h1, 4'hF, resp);
        check("status write resp", 32'(resp_okay), 32'(resp));
        expect_read("status write ignored", `BOARD_REG_STATUS, 32'h0, resp_okay);
        axil_write(4'h8, 32'h1F, 4'hF, resp);
        check("unmapped write resp", 32'(resp_slverr), 32'(resp));
        expect_read("unmapped read", 4'h8, 32'h0, resp_slverr);
        expect_read("cfg after bad write", `BOARD_REG_CFG, 32'h15, resp_okay);
        write_cfg("cfg clear", 32'h0);
        check("dip cleared", 0, 32'(dip_test));
    endtask

    task automatic passthrough_words();
        joy_raw_t [`BOARD_PLAYERS-1:0]                    joys;
        logic [`BOARD_PLAYERS-1:0][`BOARD_GAME_JOY_W-1:0] want;
        write_cfg("passthrough cfg", 32'h0);
        repeat (20) begin
            for (int p = 0; p < `BOARD_PLAYERS; p++) begin
                joys[p] = 16'($random(seed));
                want[p] = game_word(joys[p], joys[p].dirs);
            end
            drive_and_compare("passthrough", joys, want);
        end
    endtask

    task automatic rotation_patterns();
        joy_raw_t [`BOARD_PLAYERS-1:0]                    joys;
        logic [`BOARD_PLAYERS-1:0][`BOARD_GAME_JOY_W-1:0] want;
        // rotate alone, then rotate with flip
        for (int mode = 1; mode <= 3; mode += 2) begin
            write_cfg("rotation cfg", 32'(mode));
            for (int pat = 0; pat < 16; pat++) begin
                for (int p = 0; p < `BOARD_PLAYERS; p++) begin
                    joys[p]      = '0;
                    joys[p].dirs = 4'(pat + p);
                    want[p] = game_word(joys[p], turn_dirs(joys[p].dirs, 1'b1, mode[1]));
                end
                drive_and_compare($sformatf("rotation mode %0d", mode), joys, want);
            end
        end
    endtask

    task automatic four_way_sequence();
        logic [3:0] seq_in[5]  = '{4'b1000, 4'b1001, 4'b0001, 4'b1010, 4'b0000};
        logic [3:0] seq_out[5] = '{4'b1000, 4'b1000, 4'b0001, 4'b0000, 4'b0000};
        joy_raw_t [`BOARD_PLAYERS-1:0]                    joys;
        logic [`BOARD_PLAYERS-1:0][`BOARD_GAME_JOY_W-1:0] want;
        write_cfg("four-way cfg", 32'h4);
        for (int step = 0; step < 5; step++) begin
            for (int p = 0; p < `BOARD_PLAYERS; p++) begin
                joys[p]      = '0;
                joys[p].dirs = seq_in[step];
                want[p]      = game_word(joys[p], seq_out[step]);
            end
            drive_and_compare($sformatf("four-way step %0d", step), joys, want);
        end
    endtask

    task automatic pause_toggling();
        joy_raw_t [`BOARD_PLAYERS-1:0] joys;
        joys = '0;
        write_cfg("pause cfg", 32'h0);
        board_joy   = joys;
        downloading = 1'b1;
        @(negedge clk_sys);
        downloading = 1'b0;
        repeat (3) @(negedge clk_sys);
        check("pause start", 0, 32'(game_pause));
        // player 1 turns pause on and player 2 turns it off
        for (int p = 0; p < 2; p++) begin
            joys[p][`BOARD_PAUSE_BIT] = 1'b1;
            board_joy = joys;
            repeat (2) @(negedge clk_sys);
            check("pause before edge", 32'(p), 32'(game_pause));
            @(negedge clk_sys);
            check("pause toggled", 32'(p == 0), 32'(game_pause));
            repeat (4) @(negedge clk_sys);
            check("pause held button", 32'(p == 0), 32'(game_pause));
            joys[p][`BOARD_PAUSE_BIT] = 1'b0;
            board_joy = joys;
            repeat (4) @(negedge clk_sys);
        end
        write_cfg("menu pause cfg", 32'h8);
        check("menu pause", 1, 32'(game_pause));
        expect_read("pause status", `BOARD_REG_STATUS, 32'h1, resp_okay);
        downloading = 1'b1;
        @(negedge clk_sys);
        check("download clears pause", 0, 32'(game_pause));
        downloading = 1'b0;
        repeat (3) @(negedge clk_sys);
        check("pause stays clear", 0, 32'(game_pause));
    endtask

    initial begin
        seed        = 42627;
        clk_sys     = 1'b0;
        rst         = 1'b1;
        downloading = 1'b0;
        axil_req    = '0;
        board_joy   = '0;
        repeat (5) @(negedge clk_sys);
        rst = 1'b0;
        @(negedge clk_sys);
        reset_and_registers();
        passthrough_words();
        rotation_patterns();
        four_way_sequence();
        pause_toggling();
        $display("Simulation PASSED");
        $finish;
    end

    initial begin
        #(2 * test_cycles * clk_period);
        abort_run("the watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire
